/* verilog/pcie_mon_pkg.sv */
package pcie_mon_pkg;

    // Bus widths
    localparam int AXI_ADDR_W = 32;
    localparam int AXI_DATA_W = 64;

    // DMA burst shape, 256 beats of 8 bytes
    localparam logic [7:0]  BURST_LEN   = 8'd255;
    localparam logic [2:0]  BURST_SIZE  = 3'd3;
    localparam logic [1:0]  BURST_INCR  = 2'd1;
    localparam logic [31:0] BURST_BYTES = 32'd2048;
    localparam logic [31:0] BEAT_BYTES  = 32'd8;

    localparam logic [AXI_ADDR_W-1:0] DMA_TOGGLE_ADDR = 32'h0000_CCCC;
    localparam logic [AXI_DATA_W-1:0] RD_PATTERN      = 64'h0000_1234_5678_0000;

    localparam int LOG_DEPTH = 8;

    ////////////////////////////////////////
    // AXI channel payloads
    ////////////////////////////////////////
    typedef struct packed {
        logic [AXI_ADDR_W-1:0] addr;
        logic [7:0]            len;
        logic [2:0]            size;
        logic [1:0]            burst;
        logic [2:0]            prot;
        logic                  lock;
        logic [3:0]            cache;
    } axi_ax_t;

    typedef struct packed {
        logic [AXI_DATA_W-1:0]   data;
        logic [AXI_DATA_W/8-1:0] strb;
        logic                    last;
    } axi_w_t;

    typedef struct packed {
        logic [AXI_DATA_W-1:0] data;
        logic [3:0]            id;
        logic                  last;
        logic [1:0]            resp;
    } axi_r_t;

    typedef logic [1:0] axi_b_t;

    localparam axi_b_t RESP_OKAY = 2'b00;

    ////////////////////////////////////////
    // APB status port
    ////////////////////////////////////////
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [11:0] paddr;
    } apb_req_t;

    typedef struct packed {
        logic [63:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // Register map, byte addresses
    localparam logic [11:0] REG_CTRL     = 12'h000;
    localparam logic [11:0] REG_AR_BYTES = 12'h008;
    localparam logic [11:0] REG_R_BYTES  = 12'h010;
    localparam logic [11:0] REG_AR_SEC   = 12'h018;
    localparam logic [11:0] REG_R_SEC    = 12'h020;
    localparam logic [11:0] LOG_BASE     = 12'h100;
    // One region per log, AW then AR then W then R
    localparam logic [11:0] LOG_SPAN     = 12'h080;

endpackage

/* verilog/axi_target_resp.sv */
`timescale 1ns/1ps

module axi_target_resp import pcie_mon_pkg::*; (
    input  logic   i_axi_clk,
    input  logic   i_axi_reset,
    // AR and AW handshakes
    input  logic   i_arvalid,
    output logic   o_arready,
    input  logic   i_awvalid,
    output logic   o_awready,
    input  logic   i_wvalid,
    output logic   o_wready,
    // Responses
    output axi_r_t o_r,
    output logic   o_rvalid,
    input  logic   i_rready,
    output axi_b_t o_b,
    output logic   o_bvalid,
    input  logic   i_bready,
    // Accept strobes for the monitors
    output logic   o_aw_accept,
    output logic   o_ar_accept
);

    // Fixed read data, always a single-beat OKAY
    assign o_r = '{data: RD_PATTERN, id: 4'h0, last: 1'b1, resp: RESP_OKAY};
    assign o_b = RESP_OKAY;

    // One read in flight at a time
    assign o_arready   = ~o_rvalid;
    assign o_ar_accept = i_arvalid & o_arready;

    // AW and W are taken together, only with both present
    assign o_awready   = ~o_bvalid & i_awvalid & i_wvalid;
    assign o_wready    = o_awready;
    assign o_aw_accept = i_awvalid & o_awready;

    always_ff @(posedge i_axi_clk) begin
        if (i_axi_reset) begin
            o_rvalid <= 1'b0;
            o_bvalid <= 1'b0;
        end else begin
            if (o_rvalid && i_rready) begin
                o_rvalid <= 1'b0;
            end else if (o_ar_accept) begin
                o_rvalid <= 1'b1;
            end

            if (o_bvalid && i_bready) begin
                o_bvalid <= 1'b0;
            end else if (o_aw_accept) begin
                o_bvalid <= 1'b1;
            end
        end
    end

    // R beat must wait for the PCIe core
    rvalid_hold_a: assert property (
        @(posedge i_axi_clk) disable iff (i_axi_reset)
        o_rvalid && !i_rready |=> o_rvalid
    );

endmodule

/* verilog/txn_log.sv */
`timescale 1ns/1ps

module txn_log import pcie_mon_pkg::*; #(
    parameter type entry_t = axi_ax_t
) (
    input  logic   i_axi_clk,
    input  logic   i_axi_reset,
    input  logic   i_push,
    input  entry_t i_entry,
    output entry_t o_entries [LOG_DEPTH]
);

    // Newest beat lands in slot 0, oldest falls off the end
    always_ff @(posedge i_axi_clk) begin
        if (i_axi_reset) begin
            for (int i = 0; i < LOG_DEPTH; i++) begin
                o_entries[i] <= '0;
            end
        end else if (i_push) begin
            o_entries[0] <= i_entry;
            for (int i = 1; i < LOG_DEPTH; i++) begin
                o_entries[i] <= o_entries[i-1];
            end
        end
    end

endmodule

/* verilog/dma_read_gen.sv */
`timescale 1ns/1ps

module dma_read_gen import pcie_mon_pkg::*; #(
    parameter int AR_PERIOD = 32'h0010_0000
) (
    input  logic    i_axi_clk,
    input  logic    i_axi_reset,
    // Master-side write address, watched for the toggle
    input  axi_ax_t i_aw,
    input  logic    i_aw_accept,
    // Slave-side read request
    output axi_ax_t o_ar,
    output logic    o_arvalid,
    input  logic    i_arready,
    output logic    o_enable
);

    logic [31:0]           period_cnt;
    logic [AXI_ADDR_W-1:0] araddr;
    logic                  ar_fire;
    logic                  period_hit;

    assign ar_fire    = o_arvalid & i_arready;
    assign period_hit = (period_cnt == 32'd0);

    // Fixed burst fields, only the address walks
    assign o_ar = '{
        addr:  araddr,
        len:   BURST_LEN,
        size:  BURST_SIZE,
        burst: BURST_INCR,
        prot:  3'b000,
        lock:  1'b0,
        cache: 4'h0
    };

    always_ff @(posedge i_axi_clk) begin
        if (i_axi_reset) begin
            period_cnt <= 32'(AR_PERIOD);
            araddr     <= '0;
            o_arvalid  <= 1'b0;
            o_enable   <= 1'b0;
        end else begin
            period_cnt <= period_hit ? 32'(AR_PERIOD) : period_cnt - 32'd1;

            // Step by one burst once accepted
            if (ar_fire) begin
                araddr <= araddr + BURST_BYTES;
            end

            // Expiry during a pending request is dropped
            if (ar_fire) begin
                o_arvalid <= 1'b0;
            end else if (period_hit && o_enable) begin
                o_arvalid <= 1'b1;
            end

            // Host write to the toggle address flips the walker
            if (i_aw_accept && i_aw.addr == DMA_TOGGLE_ADDR) begin
                o_enable <= ~o_enable;
            end
        end
    end

    ar_stable_a: assert property (
        @(posedge i_axi_clk) disable iff (i_axi_reset)
        o_arvalid && !i_arready |=> o_arvalid && $stable(o_ar)
    );

endmodule

/* verilog/perf_counters.sv */
`timescale 1ns/1ps

module perf_counters import pcie_mon_pkg::*; (
    input  logic        i_axi_clk,
    input  logic        i_axi_reset,
    input  logic        i_pps,
    input  logic        i_ar_fire,
    input  logic        i_r_fire,
    output logic [47:0] o_ar_bytes,
    output logic [47:0] o_r_bytes,
    output logic [31:0] o_ar_sec,
    output logic [31:0] o_r_sec
);

    logic [2:0]  pps_sync;
    logic        second_tick;
    logic [31:0] ar_inc;
    logic [31:0] r_inc;
    logic [31:0] ar_acc;
    logic [31:0] r_acc;

    assign ar_inc = i_ar_fire ? BURST_BYTES : 32'd0;
    assign r_inc  = i_r_fire ? BEAT_BYTES : 32'd0;

    ////////////////////////////////////////
    // Pulse-per-second toggle to one-cycle tick
    ////////////////////////////////////////
    always_ff @(posedge i_axi_clk) begin
        if (i_axi_reset) begin
            pps_sync    <= 3'b000;
            second_tick <= 1'b0;
        end else begin
            pps_sync    <= {pps_sync[1:0], i_pps};
            // Either edge marks a new second
            second_tick <= pps_sync[2] ^ pps_sync[1];
        end
    end

    ////////////////////////////////////////
    // Running totals and per-second latches
    ////////////////////////////////////////
    always_ff @(posedge i_axi_clk) begin
        if (i_axi_reset) begin
            o_ar_bytes <= '0;
            o_r_bytes  <= '0;
            ar_acc     <= '0;
            r_acc      <= '0;
            o_ar_sec   <= '0;
            o_r_sec    <= '0;
        end else begin
            o_ar_bytes <= o_ar_bytes + {16'h0, ar_inc};
            o_r_bytes  <= o_r_bytes + {16'h0, r_inc};
            if (second_tick) begin
                o_ar_sec <= ar_acc;
                o_r_sec  <= r_acc;
                // Restart, this cycle's beat counts toward the new second
                ar_acc   <= ar_inc;
                r_acc    <= r_inc;
            end else begin
                ar_acc   <= ar_acc + ar_inc;
                r_acc    <= r_acc + r_inc;
            end
        end
    end

endmodule

/* verilog/status_apb.sv */
`timescale 1ns/1ps

module status_apb import pcie_mon_pkg::*; (
    input  logic                  i_axi_clk,
    input  logic                  i_axi_reset,
    input  apb_req_t              i_apb,
    output apb_rsp_t              o_apb,
    // Live state
    input  logic                  i_enable,
    input  logic [AXI_ADDR_W-1:0] i_araddr,
    input  logic [47:0]           i_ar_bytes,
    input  logic [47:0]           i_r_bytes,
    input  logic [31:0]           i_ar_sec,
    input  logic [31:0]           i_r_sec,
    // Logs, entry 0 newest
    input  axi_ax_t               i_aw_log [LOG_DEPTH],
    input  axi_ax_t               i_ar_log [LOG_DEPTH],
    input  axi_w_t                i_w_log  [LOG_DEPTH],
    input  axi_r_t                i_r_log  [LOG_DEPTH]
);

    logic        access;
    logic        hit;
    logic [63:0] rdata;
    logic [11:0] log_off;
    logic [1:0]  log_sel;
    logic [2:0]  entry_idx;
    logic [127:0] entry_wide;

    assign access = i_apb.psel & i_apb.penable;

    // Offset into the log window, region then entry then word
    assign log_off   = i_apb.paddr - LOG_BASE;
    assign log_sel   = log_off[8:7];
    assign entry_idx = log_off[6:4];

    always_comb begin
        case (log_sel)
            2'd0:    entry_wide = 128'(i_aw_log[entry_idx]);
            2'd1:    entry_wide = 128'(i_ar_log[entry_idx]);
            2'd2:    entry_wide = 128'(i_w_log[entry_idx]);
            default: entry_wide = 128'(i_r_log[entry_idx]);
        endcase
    end

    always_comb begin
        hit   = 1'b1;
        rdata = 64'h0;
        if (i_apb.paddr >= LOG_BASE && i_apb.paddr < LOG_BASE + 4 * LOG_SPAN &&
            i_apb.paddr[2:0] == 3'b000) begin
            rdata = log_off[3] ? entry_wide[127:64] : entry_wide[63:0];
        end else begin
            case (i_apb.paddr)
                REG_CTRL:     rdata = {i_araddr, 31'h0, i_enable};
                REG_AR_BYTES: rdata = {16'h0, i_ar_bytes};
                REG_R_BYTES:  rdata = {16'h0, i_r_bytes};
                REG_AR_SEC:   rdata = {32'h0, i_ar_sec};
                REG_R_SEC:    rdata = {32'h0, i_r_sec};
                default:      hit = 1'b0;
            endcase
        end
    end

    // Zero wait states
    assign o_apb.pready  = access;
    assign o_apb.prdata  = access ? rdata : 64'h0;
    assign o_apb.pslverr = access & ~hit;

    apb_setup_a: assert property (
        @(posedge i_axi_clk) disable iff (i_axi_reset)
        i_apb.psel && i_apb.penable |-> $past(i_apb.psel && !i_apb.penable)
    );

endmodule

/* verilog/pcie_mon_top.sv */
`timescale 1ns/1ps

module pcie_mon_top import pcie_mon_pkg::*; #(
    parameter int AR_PERIOD = 32'h0010_0000
) (
    input  logic     i_axi_clk,
    input  logic     i_axi_reset,
    input  logic     i_pps,
    // Master-AXI, driven by the PCIe core
    input  axi_ax_t  i_m_ar,
    input  logic     i_m_arvalid,
    output logic     o_m_arready,
    input  axi_ax_t  i_m_aw,
    input  logic     i_m_awvalid,
    output logic     o_m_awready,
    input  axi_w_t   i_m_w,
    input  logic     i_m_wvalid,
    output logic     o_m_wready,
    output axi_r_t   o_m_r,
    output logic     o_m_rvalid,
    input  logic     i_m_rready,
    output axi_b_t   o_m_b,
    output logic     o_m_bvalid,
    input  logic     i_m_bready,
    // Slave-AXI read, toward host memory
    output axi_ax_t  o_s_ar,
    output logic     o_s_arvalid,
    input  logic     i_s_arready,
    input  axi_r_t   i_s_r,
    input  logic     i_s_rvalid,
    output logic     o_s_rready,
    // Status
    input  apb_req_t i_apb,
    output apb_rsp_t o_apb
);

    logic        m_aw_accept;
    logic        m_ar_accept;
    logic        s_ar_fire;
    logic        s_r_fire;
    logic        dma_enable;
    logic [47:0] ar_bytes;
    logic [47:0] r_bytes;
    logic [31:0] ar_sec;
    logic [31:0] r_sec;
    axi_ax_t     aw_log [LOG_DEPTH];
    axi_ax_t     ar_log [LOG_DEPTH];
    axi_w_t      w_log  [LOG_DEPTH];
    axi_r_t      r_log  [LOG_DEPTH];

    // All read data taken at once and dropped
    assign o_s_rready = 1'b1;
    assign s_ar_fire  = o_s_arvalid & i_s_arready;
    assign s_r_fire   = i_s_rvalid & o_s_rready;

    ////////////////////////////////////////
    // Master-AXI responder
    ////////////////////////////////////////
    axi_target_resp resp_i (
        .i_axi_clk   (i_axi_clk),
        .i_axi_reset (i_axi_reset),
        .i_arvalid   (i_m_arvalid),
        .o_arready   (o_m_arready),
        .i_awvalid   (i_m_awvalid),
        .o_awready   (o_m_awready),
        .i_wvalid    (i_m_wvalid),
        .o_wready    (o_m_wready),
        .o_r         (o_m_r),
        .o_rvalid    (o_m_rvalid),
        .i_rready    (i_m_rready),
        .o_b         (o_m_b),
        .o_bvalid    (o_m_bvalid),
        .i_bready    (i_m_bready),
        .o_aw_accept (m_aw_accept),
        .o_ar_accept (m_ar_accept)
    );

    dma_read_gen #(.AR_PERIOD(AR_PERIOD)) dma_i (
        .i_axi_clk   (i_axi_clk),
        .i_axi_reset (i_axi_reset),
        .i_aw        (i_m_aw),
        .i_aw_accept (m_aw_accept),
        .o_ar        (o_s_ar),
        .o_arvalid   (o_s_arvalid),
        .i_arready   (i_s_arready),
        .o_enable    (dma_enable)
    );

    perf_counters perf_i (
        .i_axi_clk   (i_axi_clk),
        .i_axi_reset (i_axi_reset),
        .i_pps       (i_pps),
        .i_ar_fire   (s_ar_fire),
        .i_r_fire    (s_r_fire),
        .o_ar_bytes  (ar_bytes),
        .o_r_bytes   (r_bytes),
        .o_ar_sec    (ar_sec),
        .o_r_sec     (r_sec)
    );

    ////////////////////////////////////////
    // Transaction logs
    ////////////////////////////////////////
    txn_log #(.entry_t(axi_ax_t)) aw_log_i (
        .i_axi_clk (i_axi_clk), .i_axi_reset (i_axi_reset),
        .i_push    (m_aw_accept), .i_entry (i_m_aw), .o_entries (aw_log)
    );

    txn_log #(.entry_t(axi_ax_t)) ar_log_i (
        .i_axi_clk (i_axi_clk), .i_axi_reset (i_axi_reset),
        .i_push    (m_ar_accept), .i_entry (i_m_ar), .o_entries (ar_log)
    );

    // W beat is accepted in the same cycle as its AW
    txn_log #(.entry_t(axi_w_t)) w_log_i (
        .i_axi_clk (i_axi_clk), .i_axi_reset (i_axi_reset),
        .i_push    (m_aw_accept), .i_entry (i_m_w), .o_entries (w_log)
    );

    txn_log #(.entry_t(axi_r_t)) r_log_i (
        .i_axi_clk (i_axi_clk), .i_axi_reset (i_axi_reset),
        .i_push    (s_r_fire), .i_entry (i_s_r), .o_entries (r_log)
    );

    status_apb status_i (
        .i_axi_clk   (i_axi_clk),
        .i_axi_reset (i_axi_reset),
        .i_apb       (i_apb),
        .o_apb       (o_apb),
        .i_enable    (dma_enable),
        .i_araddr    (o_s_ar.addr),
        .i_ar_bytes  (ar_bytes),
        .i_r_bytes   (r_bytes),
        .i_ar_sec    (ar_sec),
        .i_r_sec     (r_sec),
        .i_aw_log    (aw_log),
        .i_ar_log    (ar_log),
        .i_w_log     (w_log),
        .i_r_log     (r_log)
    );

endmodule

/* testbench/tb_pcie_mon_tasks.svh */
`ifndef TB_PCIE_MON_TASKS_SVH
`define TB_PCIE_MON_TASKS_SVH

// Longest wait for any handshake, in cycles
localparam int WAIT_LIMIT = 200;

////////////////////////////////////////
// Failure and compare tasks
////////////////////////////////////////
task automatic stop_run();
    $display("sim failed");
    $fatal(1);
endtask

task automatic guard_wait(input int n, input string what);
    if (n > WAIT_LIMIT) begin
        $display("Timed out at %0t waiting for %s", $time, what);
        stop_run();
    end
endtask

task automatic check_ax(input string name, input axi_ax_t got, input axi_ax_t want);
    if (got !== want) begin
        $display("ERR %0t %s got %h exp %h", $time, name, got, want);
        stop_run();
    end
endtask

task automatic check_r(input string name, input axi_r_t got, input axi_r_t want);
    if (got !== want) begin
        $display("ERR %0t %s got %h exp %h", $time, name, got, want);
        stop_run();
    end
endtask

task automatic check_b(input string name, input axi_b_t got, input axi_b_t want);
    if (got !== want) begin
        $display("ERR %0t %s got %h exp %h", $time, name, got, want);
        stop_run();
    end
endtask

task automatic check_word(input string name, input logic [63:0] got, input logic [63:0] want);
    if (got !== want) begin
        $display("ERR %0t %s got %h exp %h", $time, name, got, want);
        stop_run();
    end
endtask

task automatic check_bit(input string name, input logic got, input logic want);
    if (got !== want) begin
        $display("ERR %0t %s got %b exp %b", $time, name, got, want);
        stop_run();
    end
endtask

////////////////////////////////////////
// Random payloads
////////////////////////////////////////
function automatic axi_ax_t rand_ax();
    axi_ax_t ax;
    ax.addr  = 32'($random(seed));
    ax.len   = 8'($random(seed));
    ax.size  = 3'($random(seed));
    ax.burst = 2'($random(seed));
    ax.prot  = 3'($random(seed));
    ax.lock  = 1'($random(seed));
    ax.cache = 4'($random(seed));
    // Keep random traffic off the DMA toggle
    if (ax.addr == 32'h0000_CCCC) begin
        ax.addr = ax.addr + 32'h8;
    end
    return ax;
endfunction

function automatic axi_w_t rand_w();
    axi_w_t w;
    w.data = {32'($random(seed)), 32'($random(seed))};
    w.strb = 8'($random(seed));
    w.last = 1'b1;
    return w;
endfunction

function automatic axi_r_t rand_r();
    axi_r_t r;
    r.data = {32'($random(seed)), 32'($random(seed))};
    r.id   = 4'($random(seed));
    r.last = 1'($random(seed));
    r.resp = 2'($random(seed));
    return r;
endfunction

////////////////////////////////////////
// Bus drivers
////////////////////////////////////////
task automatic master_write(input axi_ax_t aw, input axi_w_t w);
    int n;
    n = 0;
    @(negedge axi_clk);
    m_aw      = aw;
    m_w       = w;
    m_awvalid = 1'b1;
    m_wvalid  = 1'b1;
    // Ready is combinational, look once it has settled
    #1;
    while (!(m_awready && m_wready)) begin
        n++;
        guard_wait(n, "awready and wready");
        @(negedge axi_clk);
        #1;
    end
    @(negedge axi_clk);
    m_awvalid = 1'b0;
    m_wvalid  = 1'b0;
    n = 0;
    while (!m_bvalid) begin
        n++;
        guard_wait(n, "bvalid");
        @(negedge axi_clk);
    end
    check_b("m_b", m_b, 2'b00);
    m_bready = 1'b1;
    @(negedge axi_clk);
    m_bready = 1'b0;
    check_bit("m_bvalid after bready", m_bvalid, 1'b0);
endtask

task automatic master_read(input axi_ax_t ar);
    axi_r_t want;
    int     n;
    want = '{data: 64'h0000_1234_5678_0000, id: 4'h0, last: 1'b1, resp: 2'b00};
    n = 0;
    @(negedge axi_clk);
    m_ar      = ar;
    m_arvalid = 1'b1;
    #1;
    while (!m_arready) begin
        n++;
        guard_wait(n, "arready");
        @(negedge axi_clk);
        #1;
    end
    @(negedge axi_clk);
    m_arvalid = 1'b0;
    n = 0;
    while (!m_rvalid) begin
        n++;
        guard_wait(n, "rvalid");
        @(negedge axi_clk);
    end
    // R beat must hold while rready is low
    @(negedge axi_clk);
    check_bit("m_rvalid held", m_rvalid, 1'b1);
    check_r("m_r", m_r, want);
    m_rready = 1'b1;
    @(negedge axi_clk);
    m_rready = 1'b0;
    check_bit("m_rvalid after rready", m_rvalid, 1'b0);
endtask

task automatic apb_read(input logic [11:0] addr, output logic [63:0] data, output logic err);
    @(negedge axi_clk);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b0;
    apb_req.paddr   = addr;
    @(negedge axi_clk);
    apb_req.penable = 1'b1;
    #1;
    if (apb_rsp.pready !== 1'b1) begin
        $display("APB read of address %h got no pready in the access phase", addr);
        stop_run();
    end
    data = apb_rsp.prdata;
    err  = apb_rsp.pslverr;
    @(negedge axi_clk);
    apb_req = '0;
endtask

task automatic expect_reg(input string name, input logic [11:0] addr, input logic [63:0] want);
    logic [63:0] data;
    logic        err;
    apb_read(addr, data, err);
    check_bit({name, " pslverr"}, err, 1'b0);
    check_word(name, data, want);
endtask

// Region 0..3 is AW, AR, W, R
task automatic read_log(input int region, input int idx, output logic [127:0] val);
    logic [11:0] addr;
    logic [63:0] lo;
    logic [63:0] hi;
    logic        err;
    addr = 12'h100 + 12'(region * 128 + idx * 16);
    apb_read(addr, lo, err);
    check_bit("log word 0 pslverr", err, 1'b0);
    apb_read(addr + 12'h8, hi, err);
    check_bit("log word 1 pslverr", err, 1'b0);
    val = {hi, lo};
endtask

task automatic toggle_dma();
    axi_ax_t aw;
    aw      = rand_ax();
    aw.addr = 32'h0000_CCCC;
    master_write(aw, rand_w());
endtask

task automatic wait_s_arvalid();
    int n;
    n = 0;
    while (!s_arvalid) begin
        n++;
        guard_wait(n, "DMA arvalid");
        @(negedge axi_clk);
    end
endtask

task automatic expect_dma_ar(input logic [31:0] addr);
    axi_ax_t want;
    want = '{addr: addr, len: 8'd255, size: 3'd3, burst: 2'd1,
             prot: 3'b000, lock: 1'b0, cache: 4'h0};
    wait_s_arvalid();
    check_ax("s_ar", s_ar, want);
    s_arready = 1'b1;
    @(negedge axi_clk);
    s_arready = 1'b0;
    check_bit("s_arvalid after accept", s_arvalid, 1'b0);
    ar_total++;
endtask

task automatic expect_dma_idle(input int cycles);
    repeat (cycles) begin
        @(negedge axi_clk);
        check_bit("s_arvalid while disabled", s_arvalid, 1'b0);
    end
endtask

////////////////////////////////////////
// Directed tests
////////////////////////////////////////
task automatic reset_state_test();
    logic [63:0] data;
    logic        err;
    check_bit("m_rvalid", m_rvalid, 1'b0);
    check_bit("m_bvalid", m_bvalid, 1'b0);
    check_bit("s_arvalid", s_arvalid, 1'b0);
    expect_reg("REG_CTRL", 12'h000, 64'h0);
    expect_reg("REG_AR_BYTES", 12'h008, 64'h0);
    expect_reg("REG_R_BYTES", 12'h010, 64'h0);
    expect_reg("REG_AR_SEC", 12'h018, 64'h0);
    expect_reg("REG_R_SEC", 12'h020, 64'h0);
    apb_read(12'h030, data, err);
    check_bit("unmapped pslverr", err, 1'b1);
    check_word("unmapped prdata", data, 64'h0);
endtask

task automatic master_rw_test();
    axi_ax_t      ar;
    axi_ax_t      aw;
    axi_w_t       w;
    logic [127:0] val;
    logic [127:0] w_wide;
    ar = rand_ax();
    master_read(ar);
    aw = rand_ax();
    w  = rand_w();
    master_write(aw, w);
    read_log(0, 0, val);
    check_ax("aw_log[0]", val[$bits(axi_ax_t)-1:0], aw);
    check_word("aw_log[0] high", val[127:64], 64'h0);
    read_log(1, 0, val);
    check_ax("ar_log[0]", val[$bits(axi_ax_t)-1:0], ar);
    check_word("ar_log[0] high", val[127:64], 64'h0);
    w_wide = 128'(w);
    read_log(2, 0, val);
    check_word("w_log[0] low", val[63:0], w_wide[63:0]);
    check_word("w_log[0] high", val[127:64], w_wide[127:64]);
endtask

task automatic dma_walk_test();
    // Hold the slave port so the first request waits at address 0
    toggle_dma();
    expect_reg("REG_CTRL enabled", 12'h000, 64'h1);
    expect_dma_ar(32'd0);
    expect_dma_ar(32'd2048);
    expect_dma_ar(32'd4096);
    toggle_dma();
    expect_reg("REG_CTRL disabled", 12'h000, {32'd6144, 32'd0});
    expect_dma_idle(3 * AR_PERIOD);
endtask

task automatic backpressure_test();
    logic [31:0] held;
    toggle_dma();
    wait_s_arvalid();
    held = s_ar.addr;
    check_word("held araddr", 64'(held), 64'd6144);
    repeat (40) begin
        @(negedge axi_clk);
        check_bit("s_arvalid under back-pressure", s_arvalid, 1'b1);
        check_word("s_ar.addr under back-pressure", 64'(s_ar.addr), 64'(held));
    end
    expect_dma_ar(held);
    expect_dma_ar(held + 32'd2048);
    toggle_dma();
    expect_dma_idle(3 * AR_PERIOD);
endtask

task automatic byte_count_test();
    axi_r_t       beat;
    logic [127:0] val;
    logic [127:0] r_wide;
    check_bit("s_rready", s_rready, 1'b1);
    beat = '0;
    for (int i = 0; i < 6; i++) begin
        @(negedge axi_clk);
        beat     = rand_r();
        s_r      = beat;
        s_rvalid = 1'b1;
        r_total++;
    end
    @(negedge axi_clk);
    s_rvalid = 1'b0;
    expect_reg("REG_AR_BYTES", 12'h008, 64'(ar_total * 2048));
    expect_reg("REG_R_BYTES", 12'h010, 64'(r_total * 8));
    r_wide = 128'(beat);
    read_log(3, 0, val);
    check_r("r_log[0]", val[$bits(axi_r_t)-1:0], beat);
    check_word("r_log[0] high", val[127:64], r_wide[127:64]);
    // Second boundary, latch lands 4 cycles after the edge
    @(negedge axi_clk);
    pps = ~pps;
    repeat (6) @(negedge axi_clk);
    expect_reg("REG_AR_SEC", 12'h018, 64'(ar_total * 2048));
    expect_reg("REG_R_SEC", 12'h020, 64'(r_total * 8));
endtask

task automatic log_depth_test();
    axi_ax_t      hist [9];
    logic [127:0] val;
    for (int i = 0; i < 9; i++) begin
        hist[i] = rand_ax();
        master_write(hist[i], rand_w());
    end
    // Newest first, the oldest write has fallen out
    for (int i = 0; i < 8; i++) begin
        read_log(0, i, val);
        check_ax($sformatf("aw_log[%0d]", i), val[$bits(axi_ax_t)-1:0], hist[8-i]);
    end
endtask

`endif

/* testbench/tb_pcie_mon.sv */
`timescale 1ns/1ps

module tb_pcie_mon import pcie_mon_pkg::*; ();

    localparam int AR_PERIOD = 16;

    logic     axi_clk;
    logic     axi_reset;
    logic     pps;
    // Master-AXI, the testbench plays the PCIe core
    axi_ax_t  m_ar;
    logic     m_arvalid;
    logic     m_arready;
    axi_ax_t  m_aw;
    logic     m_awvalid;
    logic     m_awready;
    axi_w_t   m_w;
    logic     m_wvalid;
    logic     m_wready;
    axi_r_t   m_r;
    logic     m_rvalid;
    logic     m_rready;
    axi_b_t   m_b;
    logic     m_bvalid;
    logic     m_bready;
    // Slave-AXI read, the testbench plays host memory
    axi_ax_t  s_ar;
    logic     s_arvalid;
    logic     s_arready;
    axi_r_t   s_r;
    logic     s_rvalid;
    logic     s_rready;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;

    integer   seed;
    // Accepted slave-side beats since reset
    int       ar_total;
    int       r_total;

    pcie_mon_top #(.AR_PERIOD(AR_PERIOD)) dut_i (
        .i_axi_clk   (axi_clk),
        .i_axi_reset (axi_reset),
        .i_pps       (pps),
        .i_m_ar      (m_ar),
        .i_m_arvalid (m_arvalid),
        .o_m_arready (m_arready),
        .i_m_aw      (m_aw),
        .i_m_awvalid (m_awvalid),
        .o_m_awready (m_awready),
        .i_m_w       (m_w),
        .i_m_wvalid  (m_wvalid),
        .o_m_wready  (m_wready),
        .o_m_r       (m_r),
        .o_m_rvalid  (m_rvalid),
        .i_m_rready  (m_rready),
        .o_m_b       (m_b),
        .o_m_bvalid  (m_bvalid),
        .i_m_bready  (m_bready),
        .o_s_ar      (s_ar),
        .o_s_arvalid (s_arvalid),
        .i_s_arready (s_arready),
        .i_s_r       (s_r),
        .i_s_rvalid  (s_rvalid),
        .o_s_rready  (s_rready),
        .i_apb       (apb_req),
        .o_apb       (apb_rsp)
    );

    `include "tb_pcie_mon_tasks.svh"

    initial begin
        axi_clk = 1'b0;
        forever begin
            #5 axi_clk = ~axi_clk;
        end
    end

    initial begin
        seed      = 53074;
        ar_total  = 0;
        r_total   = 0;
        axi_reset = 1'b1;
        pps       = 1'b0;
        m_ar      = '0;
        m_arvalid = 1'b0;
        m_aw      = '0;
        m_awvalid = 1'b0;
        m_w       = '0;
        m_wvalid  = 1'b0;
        m_rready  = 1'b0;
        m_bready  = 1'b0;
        s_arready = 1'b0;
        s_r       = '0;
        s_rvalid  = 1'b0;
        apb_req   = '0;
        repeat (3) @(posedge axi_clk);
        @(negedge axi_clk);
        axi_reset = 1'b0;

        reset_state_test();
        master_rw_test();
        dma_walk_test();
        backpressure_test();
        byte_count_test();
        log_depth_test();

        $display("sim passed");
        $finish;
    end

endmodule

/* flist.f */
+incdir+testbench
verilog/pcie_mon_pkg.sv
verilog/axi_target_resp.sv
verilog/txn_log.sv
verilog/dma_read_gen.sv
verilog/perf_counters.sv
verilog/status_apb.sv
verilog/pcie_mon_top.sv
testbench/tb_pcie_mon.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_pcie_mon
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJ_DIR)
